//--- dv/gat_trace.txt
# W adr data = Wishbone write, S n = start n groups, R word = status read and compare
# E n c0 c1 c2 c3 = expected group word, coefficients as 20-bit hex
R 00000000
W 40 00000002
W 41 123456ff
W 42 00000003
W 43 00000001
W 44 00000001
W 45 00000002
W 46 000000fe
W 47 00000001
W 00 00000003
W 01 04030201
W 02 0200fd05
W 03 0007ecf6
W 04 5a5a5a01
W 05 fafb04f8
W 06 00000004
W 07 03fc000a
W 08 0002f900
W 09 03030303
W 0a ce649c9c
W 0b 00000002
W 0c 7f7f7f7f
W 0d 80808080
W 0e 00000001
W 0f 00807f80
# Single group
E 3 00010 0000e ffff9 00000
S 1
R 00000100
# Three groups, the second start lands while busy
E 3 00010 0000e ffff9 00000
E 1 ffffb 00000 00000 00000
E 4 00020 fffff 00011 fffbc
S 3
S 5
R 00000300
# All five groups under long ready-low stretches
E 3 00010 0000e ffff9 00000
E 1 ffffb 00000 00000 00000
E 4 00020 fffff 00011 fffbc
E 2 00379 0017b 00000 00000
E 1 fffcf 00000 00000 00000
S 5
R 00000500

//--- sim.f
hdl/gat_pkg.sv
hdl/feature_ram.sv
hdl/wb_host_port.sv
hdl/attention_scorer.sv
hdl/coef_fifo.sv
hdl/gat_attention_top.sv
dv/tb_gat_attention.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_gat_attention \
  -f sim.f -o tb_gat_attention &&
out=$(./obj_dir/tb_gat_attention) &&
echo "$out" &&
echo "$out" | grep -qx "NO ERRORS" ||
{ echo "Simulation failed"; exit 1; }

//--- dv/tb_gat_attention.sv
`timescale 1ns/1ps
`default_nettype none

module tb_gat_attention import gat_pkg::*; ();

  localparam int CLK_PERIOD       = 100;
  localparam int WB_TIMEOUT       = 20;
  localparam int RUN_TIMEOUT      = 5000;
  localparam int LANES_W          = MAX_NODES * ACC_WIDTH;
  localparam int LONG_STALL_START = 4;

  logic                  clk;
  logic                  rst_n;
  logic                  wb_cyc;
  logic                  wb_stb;
  logic                  wb_we;
  logic [WB_ADDR_W-1:0]  wb_adr;
  logic [WB_WIDTH-1:0]   wb_dat;
  logic [WB_WIDTH-1:0]   wb_dat_rd;
  logic                  wb_ack;
  logic                  coef_valid;
  logic                  coef_ready;
  logic [LANES_W-1:0]    coef_data;
  logic [NODE_CNT_W-1:0] coef_count;

  logic [LANES_W-1:0]    exp_data_q[$];
  logic [NODE_CNT_W-1:0] exp_count_q[$];
  integer                seed;
  int                    errors;
  int                    words_seen;
  int                    starts_sent;
  bit                    long_stalls;
  bit                    abort;

  gat_attention_top i_dut (
    .clk          (clk        ),
    .rst_n        (rst_n      ),
    .wb_cyc_i     (wb_cyc     ),
    .wb_stb_i     (wb_stb     ),
    .wb_we_i      (wb_we      ),
    .wb_adr_i     (wb_adr     ),
    .wb_dat_i     (wb_dat     ),
    .wb_dat_o     (wb_dat_rd  ),
    .wb_ack_o     (wb_ack     ),
    .coef_valid_o (coef_valid ),
    .coef_ready_i (coef_ready ),
    .coef_data_o  (coef_data  ),
    .coef_count_o (coef_count )
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  task automatic report_mismatch(input string signal, input logic [LANES_W-1:0] expected,
                                 input logic [LANES_W-1:0] actual);
    errors++;
    $display("Fail at %0t ns: %s expected %0h, actual %0h", $time, signal, expected, actual);
  endtask

  task automatic check_fields(input int got, input int want, input logic [7:0] cmd);
    assert (got == want) else begin
      errors++;
      abort = 1'b1;
      $display("Trace line %c holds %0d fields where %0d were expected", cmd, got, want);
    end
  endtask

  // One Wishbone classic cycle held until ack or timeout
  task automatic wb_access(input logic we, input logic [WB_ADDR_W-1:0] adr,
                           input logic [WB_WIDTH-1:0] wdata, output logic [WB_WIDTH-1:0] rdata);
    int cycles;
    @(posedge clk);
    #1;
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = we;
    wb_adr = adr;
    wb_dat = wdata;
    cycles = 0;
    do begin
      @(posedge clk);
      #1;
      cycles++;
    end while (!wb_ack && cycles < WB_TIMEOUT);
    rdata  = wb_dat_rd;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    assert (wb_ack) else begin
      errors++;
      abort = 1'b1;
      $display("No wb_ack_o within %0d cycles for access to address %h", WB_TIMEOUT, adr);
    end
  endtask

  task automatic wait_drained();
    int cycles;
    cycles = 0;
    while (exp_data_q.size() != 0 && cycles < RUN_TIMEOUT) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    assert (exp_data_q.size() == 0) else begin
      errors++;
      abort = 1'b1;
      $display("%0d expected coefficient words never arrived", exp_data_q.size());
    end
  endtask

  task automatic check_word();
    logic [LANES_W-1:0]    exp_data;
    logic [NODE_CNT_W-1:0] exp_count;
    words_seen++;
    assert (exp_data_q.size() != 0) else begin
      errors++;
      $display("Extra word on the coefficient stream at %0t ns, none was expected", $time);
    end
    if (exp_data_q.size() != 0) begin
      exp_data  = exp_data_q.pop_front();
      exp_count = exp_count_q.pop_front();
      assert (coef_count == exp_count) else report_mismatch("coef_count_o", exp_count, coef_count);
      for (int k = 0; k < MAX_NODES; k++) begin
        assert (coef_data[k*ACC_WIDTH +: ACC_WIDTH] == exp_data[k*ACC_WIDTH +: ACC_WIDTH])
          else report_mismatch($sformatf("coef_data_o lane %0d", k),
                               exp_data[k*ACC_WIDTH +: ACC_WIDTH],
                               coef_data[k*ACC_WIDTH +: ACC_WIDTH]);
      end
    end
  endtask

  // Random ready on the output side with transfer and hold checks
  initial begin
    bit                    held;
    logic [LANES_W-1:0]    held_data;
    logic [NODE_CNT_W-1:0] held_count;
    int                    stall;
    held       = 1'b0;
    stall      = 0;
    coef_ready = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      if (held) begin
        assert (coef_valid) else report_mismatch("coef_valid_o held", 1, coef_valid);
        assert (coef_data == held_data) else report_mismatch("coef_data_o held", held_data,
                                                             coef_data);
        assert (coef_count == held_count) else report_mismatch("coef_count_o held", held_count,
                                                               coef_count);
      end
      if (stall > 0) begin
        coef_ready = 1'b0;
        stall--;
      end else if (long_stalls && ($random(seed) & 3) == 0) begin
        coef_ready = 1'b0;
        stall      = 15 + ($random(seed) & 15);
      end else begin
        coef_ready = ($random(seed) & 3) != 0;
      end
      held       = coef_valid && !coef_ready;
      held_data  = coef_data;
      held_count = coef_count;
      if (coef_valid && coef_ready) begin
        check_word();
      end
    end
  end

  initial begin
    int                   fd;
    int                   n;
    logic [7:0]           cmd;
    logic [31:0]          arg;
    logic [WB_WIDTH-1:0]  wdata;
    logic [WB_WIDTH-1:0]  rdata;
    logic [ACC_WIDTH-1:0] c0;
    logic [ACC_WIDTH-1:0] c1;
    logic [ACC_WIDTH-1:0] c2;
    logic [ACC_WIDTH-1:0] c3;
    logic [8*128-1:0]     skip;
    seed        = 32'he597;
    errors      = 0;
    words_seen  = 0;
    starts_sent = 0;
    long_stalls = 1'b0;
    abort       = 1'b0;
    rst_n       = 1'b0;
    wb_cyc      = 1'b0;
    wb_stb      = 1'b0;
    wb_we       = 1'b0;
    wb_adr      = '0;
    wb_dat      = '0;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    assert (!coef_valid) else report_mismatch("coef_valid_o after reset", 0, coef_valid);

    fd = $fopen("dv/gat_trace.txt", "r");
    if (fd == 0) begin
      errors++;
      abort = 1'b1;
      $display("Could not open the trace file dv/gat_trace.txt");
    end
    while (!abort && $fscanf(fd, " %c", cmd) == 1) begin
      case (cmd)
        "#": n = $fgets(skip, fd);
        "W": begin
          n = $fscanf(fd, "%h %h", arg, wdata);
          check_fields(n, 2, cmd);
          wb_access(1'b1, arg[WB_ADDR_W-1:0], wdata, rdata);
        end
        "S": begin
          n = $fscanf(fd, "%h", wdata);
          check_fields(n, 1, cmd);
          starts_sent++;
          long_stalls = (starts_sent >= LONG_STALL_START);
          wb_access(1'b1, {REGION_CTRL, ADDR_START}, wdata, rdata);
        end
        "E": begin
          n = $fscanf(fd, "%h %h %h %h %h", arg, c0, c1, c2, c3);
          check_fields(n, 5, cmd);
          exp_count_q.push_back(arg[NODE_CNT_W-1:0]);
          exp_data_q.push_back({c3, c2, c1, c0});
        end
        "R": begin
          n = $fscanf(fd, "%h", wdata);
          check_fields(n, 1, cmd);
          wait_drained();
          if (!abort) begin
            wb_access(1'b0, {REGION_CTRL, ADDR_STATUS}, '0, rdata);
            assert (rdata == wdata) else report_mismatch("wb_dat_o status", wdata, rdata);
          end
        end
        default: begin
          errors++;
          abort = 1'b1;
          $display("Trace holds an unknown command character %h", cmd);
        end
      endcase
    end
    if (!abort) begin
      wait_drained();
    end
    if (fd != 0) begin
      $fclose(fd);
    end

    $display("Summary: %0d coefficient words checked, %0d errors", words_seen, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- hdl/gat_attention_top.sv
`timescale 1ns/1ps
`default_nettype none

module gat_attention_top import gat_pkg::*; (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           wb_cyc_i,
  input  logic                           wb_stb_i,
  input  logic                           wb_we_i,
  input  logic [WB_ADDR_W-1:0]           wb_adr_i,
  input  logic [WB_WIDTH-1:0]            wb_dat_i,
  output logic [WB_WIDTH-1:0]            wb_dat_o,
  output logic                           wb_ack_o,
  output logic                           coef_valid_o,
  input  logic                           coef_ready_i,
  output logic [MAX_NODES*ACC_WIDTH-1:0] coef_data_o,
  output logic [NODE_CNT_W-1:0]          coef_count_o
);

  logic                   wh_we;
  logic [WH_ADDR_W-1:0]   wh_waddr;
  logic [WB_WIDTH-1:0]    wh_wdata;
  logic [WH_ADDR_W-1:0]   wh_raddr;
  logic [WB_WIDTH-1:0]    wh_rdata;
  logic                   a_we;
  logic [A_ADDR_W-1:0]    a_waddr;
  logic [DATA_WIDTH-1:0]  a_wdata;
  logic [A_ADDR_W-1:0]    a_raddr;
  logic [DATA_WIDTH-1:0]  a_rdata;
  logic                   run_start;
  logic [GROUP_W-1:0]     num_groups;
  logic                   busy;
  logic [GROUP_W-1:0]     groups_done;
  logic                   push;
  logic [COEF_WORD_W-1:0] group_word;
  logic [COEF_WORD_W-1:0] fifo_dout;
  logic                   fifo_full;
  logic                   fifo_empty;
  logic                   pop;

  // Output stream straight off the FIFO head
  assign coef_valid_o = ~fifo_empty;
  assign pop          = coef_valid_o & coef_ready_i;
  assign coef_data_o  = fifo_dout[COEF_WORD_W-1:NODE_CNT_W];
  assign coef_count_o = fifo_dout[NODE_CNT_W-1:0];

  wb_host_port i_host (
    .clk           (clk          ),
    .rst_n         (rst_n        ),
    .wb_cyc_i      (wb_cyc_i     ),
    .wb_stb_i      (wb_stb_i     ),
    .wb_we_i       (wb_we_i      ),
    .wb_adr_i      (wb_adr_i     ),
    .wb_dat_i      (wb_dat_i     ),
    .wb_dat_o      (wb_dat_o     ),
    .wb_ack_o      (wb_ack_o     ),
    .busy_i        (busy         ),
    .groups_done_i (groups_done  ),
    .wh_we_o       (wh_we        ),
    .wh_waddr_o    (wh_waddr     ),
    .wh_wdata_o    (wh_wdata     ),
    .a_we_o        (a_we         ),
    .a_waddr_o     (a_waddr      ),
    .a_wdata_o     (a_wdata      ),
    .run_start_o   (run_start    ),
    .num_groups_o  (num_groups   )
  );

  feature_ram #(
    .WIDTH   (WB_WIDTH ),
    .DEPTH   (WH_DEPTH )
  ) i_wh_ram (
    .clk     (clk      ),
    .we_i    (wh_we    ),
    .waddr_i (wh_waddr ),
    .wdata_i (wh_wdata ),
    .raddr_i (wh_raddr ),
    .rdata_o (wh_rdata )
  );

  feature_ram #(
    .WIDTH   (DATA_WIDTH ),
    .DEPTH   (A_DEPTH    )
  ) i_a_ram (
    .clk     (clk        ),
    .we_i    (a_we       ),
    .waddr_i (a_waddr    ),
    .wdata_i (a_wdata    ),
    .raddr_i (a_raddr    ),
    .rdata_o (a_rdata    )
  );

  attention_scorer i_scorer (
    .clk           (clk         ),
    .rst_n         (rst_n       ),
    .run_start_i   (run_start   ),
    .num_groups_i  (num_groups  ),
    .wh_rdata_i    (wh_rdata    ),
    .a_rdata_i     (a_rdata     ),
    .fifo_full_i   (fifo_full   ),
    .wh_raddr_o    (wh_raddr    ),
    .a_raddr_o     (a_raddr     ),
    .push_o        (push        ),
    .group_word_o  (group_word  ),
    .busy_o        (busy        ),
    .groups_done_o (groups_done )
  );

  coef_fifo i_fifo (
    .clk     (clk        ),
    .rst_n   (rst_n      ),
    .push_i  (push       ),
    .data_i  (group_word ),
    .pop_i   (pop        ),
    .data_o  (fifo_dout  ),
    .full_o  (fifo_full  ),
    .empty_o (fifo_empty )
  );

endmodule

`default_nettype wire

//--- hdl/coef_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module coef_fifo import gat_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   push_i,
  input  logic [COEF_WORD_W-1:0] data_i,
  input  logic                   pop_i,
  output logic [COEF_WORD_W-1:0] data_o,
  output logic                   full_o,
  output logic                   empty_o
);

  logic [COEF_WORD_W-1:0] mem [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0]  wr_ptr;
  logic [FIFO_PTR_W-1:0]  rd_ptr;
  logic [FIFO_PTR_W:0]    count;
  logic                   do_push;
  logic                   do_pop;

  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  assign full_o  = (count == FIFO_DEPTH);
  assign empty_o = (count == '0);

  // Head word is shown straight from the buffer
  assign data_o = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= data_i;
    end
  end

endmodule

`default_nettype wire

//--- hdl/attention_scorer.sv
`timescale 1ns/1ps
`default_nettype none

module attention_scorer import gat_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   run_start_i,
  input  logic [GROUP_W-1:0]     num_groups_i,
  input  logic [WB_WIDTH-1:0]    wh_rdata_i,
  input  logic [DATA_WIDTH-1:0]  a_rdata_i,
  input  logic                   fifo_full_i,
  output logic [WH_ADDR_W-1:0]   wh_raddr_o,
  output logic [A_ADDR_W-1:0]    a_raddr_o,
  output logic                   push_o,
  output logic [COEF_WORD_W-1:0] group_word_o,
  output logic                   busy_o,
  output logic [GROUP_W-1:0]     groups_done_o
);

  logic [ST_W-1:0]                     state;
  logic [A_ADDR_W:0]                   a_cnt;
  logic [A_ADDR_W-1:0]                 a_idx;
  logic [A_DEPTH-1:0][DATA_WIDTH-1:0]  a_vec;
  logic [WH_ADDR_W-1:0]                hdr_ptr;
  logic [NODE_CNT_W-1:0]               n_q;
  logic [NODE_CNT_W-1:0]               node_idx;
  logic [NODE_CNT_W-1:0]               lane_idx_q;
  logic                                lane_en_q;
  logic                                node_valid;
  logic                                last_group;
  wh_word_u                            wh_word;
  logic signed [ACC_WIDTH-1:0]         self_dot;
  logic signed [ACC_WIDTH-1:0]         node_dot;
  logic signed [ACC_WIDTH-1:0]         self_q;
  logic signed [ACC_WIDTH-1:0]         node_q;
  logic signed [ACC_WIDTH-1:0]         sum;
  logic signed [ACC_WIDTH-1:0]         coef;
  logic [MAX_NODES-1:0][ACC_WIDTH-1:0] lanes;

  function automatic logic signed [ACC_WIDTH-1:0] dot4(
    input logic [WB_WIDTH-1:0] av,
    input logic [WB_WIDTH-1:0] fv
  );
    logic signed [ACC_WIDTH-1:0] acc;
    acc = '0;
    for (int i = 0; i < FEAT_NUM; i++) begin
      acc = acc + $signed(av[i*DATA_WIDTH +: DATA_WIDTH])
                * $signed(fv[i*DATA_WIDTH +: DATA_WIDTH]);
    end
    return acc;
  endfunction

  assign wh_word = wh_rdata_i;

  // a[0..3] weighs the target node, a[4..7] the neighbour
  assign self_dot = dot4(a_vec[FEAT_NUM-1:0], wh_word.feat);
  assign node_dot = dot4(a_vec[A_DEPTH-1:FEAT_NUM], wh_word.feat);

  // LeakyReLU on the registered partial sums
  assign sum  = self_q + node_q;
  assign coef = sum[ACC_WIDTH-1] ? (sum >>> LEAKY_SHIFT) : sum;

  assign a_raddr_o  = a_cnt[A_ADDR_W-1:0];
  assign a_idx      = A_ADDR_W'(a_cnt - 1'b1);
  assign node_valid = (state == ST_NODES) && (node_idx < n_q);
  assign last_group = (groups_done_o + 1'b1) == num_groups_i;

  assign busy_o       = (state != ST_IDLE);
  assign push_o       = (state == ST_PUSH) && !fifo_full_i;
  assign group_word_o = {lanes, n_q};

  // Next header is addressed during the last node, so it is
  // already on the read port by the time the group is pushed
  always_comb begin
    case (state)
      ST_HEADER: wh_raddr_o = hdr_ptr + 1'b1;
      ST_NODES: begin
        if ((node_idx + 1'b1) < n_q) begin
          wh_raddr_o = hdr_ptr + node_idx + 2'd2;
        end else begin
          wh_raddr_o = hdr_ptr + n_q + 1'b1;
        end
      end
      ST_PUSH:  wh_raddr_o = hdr_ptr + n_q + 1'b1;
      default:  wh_raddr_o = hdr_ptr;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state         <= ST_IDLE;
      a_cnt         <= '0;
      hdr_ptr       <= '0;
      node_idx      <= '0;
      groups_done_o <= '0;
      lane_en_q     <= 1'b0;
    end else begin
      lane_en_q <= node_valid;
      case (state)
        ST_IDLE: begin
          if (run_start_i) begin
            state         <= ST_LOAD_A;
            a_cnt         <= '0;
            hdr_ptr       <= '0;
            groups_done_o <= '0;
          end
        end
        ST_LOAD_A: begin
          a_cnt <= a_cnt + 1'b1;
          if (a_cnt == A_DEPTH) begin
            state <= (num_groups_i == '0) ? ST_IDLE : ST_HEADER;
          end
        end
        ST_HEADER: begin
          node_idx <= '0;
          state    <= ST_NODES;
        end
        ST_NODES: begin
          // One extra cycle drains the last lane
          node_idx <= node_idx + 1'b1;
          if (node_idx == n_q) begin
            state <= ST_PUSH;
          end
        end
        ST_PUSH: begin
          // Full FIFO holds everything in place
          if (!fifo_full_i) begin
            hdr_ptr       <= hdr_ptr + n_q + 1'b1;
            groups_done_o <= groups_done_o + 1'b1;
            state         <= last_group ? ST_IDLE : ST_HEADER;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state == ST_LOAD_A) && (a_cnt != '0)) begin
      a_vec[a_idx] <= a_rdata_i;
    end
    if (state == ST_HEADER) begin
      n_q   <= wh_word.hdr.cnt;
      lanes <= '0;
    end
    if (node_valid) begin
      if (node_idx == '0) begin
        self_q <= self_dot;
      end
      node_q     <= node_dot;
      lane_idx_q <= node_idx;
    end
    if (lane_en_q) begin
      lanes[lane_idx_q] <= coef;
    end
  end

endmodule

`default_nettype wire

//--- hdl/wb_host_port.sv
`timescale 1ns/1ps
`default_nettype none

module wb_host_port import gat_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  wb_cyc_i,
  input  logic                  wb_stb_i,
  input  logic                  wb_we_i,
  input  logic [WB_ADDR_W-1:0]  wb_adr_i,
  input  logic [WB_WIDTH-1:0]   wb_dat_i,
  output logic [WB_WIDTH-1:0]   wb_dat_o,
  output logic                  wb_ack_o,
  input  logic                  busy_i,
  input  logic [GROUP_W-1:0]    groups_done_i,
  output logic                  wh_we_o,
  output logic [WH_ADDR_W-1:0]  wh_waddr_o,
  output logic [WB_WIDTH-1:0]   wh_wdata_o,
  output logic                  a_we_o,
  output logic [A_ADDR_W-1:0]   a_waddr_o,
  output logic [DATA_WIDTH-1:0] a_wdata_o,
  output logic                  run_start_o,
  output logic [GROUP_W-1:0]    num_groups_o
);

  logic                  access;
  logic                  run_busy;
  logic                  wr_ok;
  logic                  start_wr;
  logic                  status_rd;
  logic [1:0]            region;
  logic [CTRL_OFS_W-1:0] offset;
  logic [WB_WIDTH-1:0]   status_word;

  // New access on the first cycle of a strobe
  assign access = wb_cyc_i & wb_stb_i & ~wb_ack_o;
  assign region = wb_adr_i[WB_ADDR_W-1 -: 2];
  assign offset = wb_adr_i[CTRL_OFS_W-1:0];

  // Start pulse counts as busy until the scorer picks it up
  assign run_busy = busy_i | run_start_o;
  assign wr_ok    = access & wb_we_i & ~run_busy;

  assign wh_we_o    = wr_ok && (region == REGION_WH);
  assign wh_waddr_o = wb_adr_i[WH_ADDR_W-1:0];
  assign wh_wdata_o = wb_dat_i;

  // Only the low byte goes into the a memory
  assign a_we_o    = wr_ok && (region == REGION_A);
  assign a_waddr_o = wb_adr_i[A_ADDR_W-1:0];
  assign a_wdata_o = wb_dat_i[DATA_WIDTH-1:0];

  assign start_wr  = wr_ok && (region == REGION_CTRL) && (offset == ADDR_START);
  assign status_rd = access && !wb_we_i && (region == REGION_CTRL) && (offset == ADDR_STATUS);

  assign status_word = {{(WB_WIDTH-2*GROUP_W){1'b0}}, groups_done_i,
                        {(GROUP_W-1){1'b0}}, run_busy};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wb_ack_o    <= 1'b0;
      run_start_o <= 1'b0;
    end else begin
      wb_ack_o    <= access;
      run_start_o <= start_wr;
    end
  end

  always_ff @(posedge clk) begin
    if (start_wr) begin
      num_groups_o <= wb_dat_i[GROUP_W-1:0];
    end
    if (access) begin
      wb_dat_o <= status_rd ? status_word : '0;
    end
  end

endmodule

`default_nettype wire

//--- hdl/feature_ram.sv
`timescale 1ns/1ps
`default_nettype none

module feature_ram #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 8
) (
  input  logic                     clk,
  input  logic                     we_i,
  input  logic [$clog2(DEPTH)-1:0] waddr_i,
  input  logic [WIDTH-1:0]         wdata_i,
  input  logic [$clog2(DEPTH)-1:0] raddr_i,
  output logic [WIDTH-1:0]         rdata_o
);

  logic [WIDTH-1:0] mem [DEPTH];

  // Read data lags the address by one cycle
  always_ff @(posedge clk) begin
    if (we_i) begin
      mem[waddr_i] <= wdata_i;
    end
    rdata_o <= mem[raddr_i];
  end

endmodule

`default_nettype wire

//--- hdl/gat_pkg.sv
`default_nettype none

package gat_pkg;

  // Feature and attention element format
  localparam int DATA_WIDTH  = 8;
  localparam int FEAT_NUM    = 4;
  localparam int WB_WIDTH    = FEAT_NUM * DATA_WIDTH;
  localparam int WB_ADDR_W   = 8;

  // Memory sizes
  localparam int WH_DEPTH    = 64;
  localparam int WH_ADDR_W   = 6;
  localparam int A_DEPTH     = 2 * FEAT_NUM;
  localparam int A_ADDR_W    = 3;

  // Group and coefficient format
  localparam int MAX_NODES   = 4;
  localparam int NODE_CNT_W  = 3;
  localparam int ACC_WIDTH   = 20;
  localparam int LEAKY_SHIFT = 3;
  localparam int COEF_WORD_W = MAX_NODES * ACC_WIDTH + NODE_CNT_W;
  localparam int GROUP_W     = 8;

  // Coefficient FIFO
  localparam int FIFO_DEPTH  = 4;
  localparam int FIFO_PTR_W  = 2;

  // Host address map, region in word-address bits 7:6
  localparam int CTRL_OFS_W  = 6;
  localparam logic [1:0] REGION_WH   = 2'd0;
  localparam logic [1:0] REGION_A    = 2'd1;
  localparam logic [1:0] REGION_CTRL = 2'd2;
  localparam logic [CTRL_OFS_W-1:0] ADDR_START  = 6'd0;
  localparam logic [CTRL_OFS_W-1:0] ADDR_STATUS = 6'd1;

  // Scorer FSM states
  localparam int ST_W = 3;
  localparam logic [ST_W-1:0] ST_IDLE   = 3'd0;
  localparam logic [ST_W-1:0] ST_LOAD_A = 3'd1;
  localparam logic [ST_W-1:0] ST_HEADER = 3'd2;
  localparam logic [ST_W-1:0] ST_NODES  = 3'd3;
  localparam logic [ST_W-1:0] ST_PUSH   = 3'd4;

  // One WH memory word, either a group header or a feature vector.
  // Feature elements are signed, element 0 in the low byte
  typedef union packed {
    logic [FEAT_NUM-1:0][DATA_WIDTH-1:0] feat;
    struct packed {
      logic [WB_WIDTH-NODE_CNT_W-1:0] pad;
      logic [NODE_CNT_W-1:0]          cnt;
    } hdr;
  } wh_word_u;

endpackage

`default_nettype wire
